/* list.f */
wb_pkg.sv
cmd_pkg.sv
wb_cmd_decode.sv
wb_beat_issue.sv
wb_ack_gather.sv
wb_ram_slave.sv
wb_burst_top.sv
tb_wb_burst.sv

/* run.sh */
#!/bin/sh
# Build and run the Wishbone burst bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_wb_burst -o sim_wb_burst

out=$(./obj_dir/sim_wb_burst 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

/* tb_wb_burst.sv */
module tb_wb_burst;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ENTRIES    = 15;
    localparam int QUIET_ENTRIES  = 6;                  // First block runs without stall.
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40;
    localparam int NUM_BEATS      = cmd_pkg::NUM_BEATS;
    localparam int BEAT_W         = wb_pkg::WB_DATA_W;

    typedef struct packed {
        logic             we;
        wb_pkg::wb_addr_t addr;
        logic [63:0]      data;
        logic             err;
    } entry_t;

    logic               wb_clk = 1'b0;
    logic               wb_rst;
    logic               cmd_req;
    cmd_pkg::cmd_t      cmd;
    logic               slv_stall = 1'b0;
    logic               cmd_ack;
    logic               cmd_err;
    cmd_pkg::cmd_data_t rd_data;

    entry_t           stim [NUM_ENTRIES];
    wb_pkg::wb_data_t shadow [wb_pkg::WB_MEM_DEPTH];
    logic [31:0]      lfsr = 32'h449b_9849;
    logic             stall_en = 1'b0;
    logic             next_stall;
    int               cycles = 0;
    int               beat_cnt;
    logic             cur_we;
    wb_pkg::wb_addr_t cur_addr;
    logic [63:0]      cur_data;

    wb_burst_top i_dut (
        .i_wb_clk    (wb_clk),
        .i_wb_rst    (wb_rst),
        .i_cmd_req   (cmd_req),
        .i_cmd       (cmd),
        .i_slv_stall (slv_stall),
        .o_cmd_ack   (cmd_ack),
        .o_cmd_err   (cmd_err),
        .o_rd_data   (rd_data)
    );

    always #4 wb_clk = ~wb_clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // Stall bit lands 1 ns after the edge that samples the enable.
    always @(posedge wb_clk) begin
        if (stall_en) begin
            next_stall = lfsr[0];
            lfsr       = lfsr_step(lfsr);
        end else begin
            next_stall = 1'b0;
        end
        #1 slv_stall = next_stall;
    end

    always @(posedge wb_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no command completion after %0d cycles", cycles);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    // Every accepted beat must be the next one of the current command.
    always @(negedge wb_clk) begin
        if (i_dut.bus_req.stb && !slv_stall) begin
            compare(64'(beat_cnt < NUM_BEATS), 64'(1), "extra beat on the bus");
            compare(64'(i_dut.bus_req.addr), 64'(cur_addr + wb_pkg::wb_addr_t'(2 * beat_cnt)),
                    "beat address");
            compare(64'(i_dut.bus_req.we), 64'(cur_we), "beat direction");
            if (cur_we) begin
                compare(64'(i_dut.bus_req.data), 64'(cur_data[BEAT_W*beat_cnt +: BEAT_W]),
                        "beat write data");
            end
            beat_cnt = beat_cnt + 1;
        end
    end

    task automatic run_command(input entry_t e);
        int          t_req;
        int          base_idx;
        logic [63:0] exp_data;
        base_idx = int'(e.addr) / 2;
        exp_data = '0;
        cur_we   = e.we;
        cur_addr = e.addr;
        cur_data = e.data;
        beat_cnt = 0;
        cmd      = '{we: e.we, addr: e.addr, data: e.data};
        cmd_req  = 1'b1;
        t_req    = cycles;
        do begin
            @(posedge wb_clk);
            #1;
        end while (!cmd_ack);
        if (!stall_en) begin
            compare(64'(cycles - t_req), 64'(e.err ? 1 : 8), "ack latency");
        end
        compare(64'(cmd_err), 64'(e.err), "error flag");
        compare(64'(beat_cnt), 64'(e.err ? 0 : NUM_BEATS), "beats per command");
        if (e.err) begin
            compare(rd_data, 64'(0), "read data of rejected command");
        end else if (!e.we) begin
            for (int k = 0; k < NUM_BEATS; k++) begin
                exp_data[BEAT_W*k +: BEAT_W] = shadow[base_idx + k];
            end
            compare(rd_data, exp_data, "read data");
        end
        cmd_req = 1'b0;
        @(posedge wb_clk);
        #1;
        compare(64'(cmd_ack), 64'(1), "ack held until req seen low");
        do begin
            @(posedge wb_clk);
            #1;
        end while (cmd_ack);
        if (e.we && !e.err) begin
            for (int k = 0; k < NUM_BEATS; k++) begin
                shadow[base_idx + k] = e.data[BEAT_W*k +: BEAT_W];  // Beat 0 is low word.
            end
        end
    endtask

    initial begin
        wb_rst  = 1'b1;
        cmd_req = 1'b0;
        cmd     = '0;
        stim = '{
            '{1'b1, 12'h040, 64'h1122_3344_5566_7788, 1'b0},
            '{1'b0, 12'h040, 64'h0,                   1'b0},
            '{1'b1, 12'h048, 64'ha5a5_5a5a_0f0f_f0f0, 1'b0},
            '{1'b1, 12'h04c, 64'hdead_beef_dead_beef, 1'b1},  // Lands inside 0x048.
            '{1'b0, 12'h048, 64'h0,                   1'b0},
            '{1'b0, 12'h043, 64'h0,                   1'b1},
            '{1'b1, 12'h100, 64'h0123_4567_89ab_cdef, 1'b0},
            '{1'b1, 12'h208, 64'hfedc_ba98_7654_3210, 1'b0},
            '{1'b1, 12'h7f8, 64'hc3c3_3c3c_9696_6969, 1'b0},
            '{1'b1, 12'hff8, 64'h8001_4002_2004_1008, 1'b0},
            '{1'b0, 12'h7f8, 64'h0,                   1'b0},
            '{1'b0, 12'hff8, 64'h0,                   1'b0},
            '{1'b0, 12'h100, 64'h0,                   1'b0},
            '{1'b0, 12'h208, 64'h0,                   1'b0},
            '{1'b0, 12'h040, 64'h0,                   1'b0}
        };
        repeat (4) @(posedge wb_clk);
        #1;
        compare(64'(cmd_ack), 64'(0), "ack during reset");
        wb_rst = 1'b0;
        @(posedge wb_clk);
        #1;
        compare(64'(cmd_ack), 64'(0), "ack after reset");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            stall_en = (i >= QUIET_ENTRIES);
            run_command(stim[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* wb_burst_top.sv */
module wb_burst_top (
    input  logic               i_wb_clk,
    input  logic               i_wb_rst,
    input  logic               i_cmd_req,
    input  cmd_pkg::cmd_t      i_cmd,
    input  logic               i_slv_stall,
    output logic               o_cmd_ack,
    output logic               o_cmd_err,
    output cmd_pkg::cmd_data_t o_rd_data
);

    logic               start;
    logic               done;
    cmd_pkg::plan_t     plan;
    cmd_pkg::cmd_data_t gath_data;
    wb_pkg::wb_req_t    bus_req;
    wb_pkg::wb_rsp_t    bus_rsp;

    wb_cmd_decode u_decode (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_cmd_req   (i_cmd_req),
        .i_cmd       (i_cmd),
        .o_cmd_ack   (o_cmd_ack),
        .o_cmd_err   (o_cmd_err),
        .o_rd_data   (o_rd_data),
        .o_start     (start),
        .o_plan      (plan),
        .i_done      (done),
        .i_gath_data (gath_data)
    );

    wb_beat_issue u_issue (
        .i_wb_clk (i_wb_clk),
        .i_wb_rst (i_wb_rst),
        .i_start  (start),
        .i_plan   (plan),
        .i_stall  (i_slv_stall),
        .i_done   (done),
        .o_bus    (bus_req)
    );

    wb_ack_gather u_gather (
        .i_wb_clk  (i_wb_clk),
        .i_wb_rst  (i_wb_rst),
        .i_start   (start),
        .i_rsp     (bus_rsp),
        .o_done    (done),
        .o_rd_data (gath_data)
    );

    wb_ram_slave u_ram (
        .i_wb_clk (i_wb_clk),
        .i_wb_rst (i_wb_rst),
        .i_bus    (bus_req),
        .i_stall  (i_slv_stall),
        .o_rsp    (bus_rsp)
    );

endmodule

/* wb_ram_slave.sv */
module wb_ram_slave (
    input  logic            i_wb_clk,
    input  logic            i_wb_rst,
    input  wb_pkg::wb_req_t i_bus,
    input  logic            i_stall,
    output wb_pkg::wb_rsp_t o_rsp
);

    wb_pkg::wb_data_t             mem [wb_pkg::WB_MEM_DEPTH];
    logic [wb_pkg::WB_ADDR_W-2:0] word_idx;
    logic                         accept;
    logic                         ack_q;
    wb_pkg::wb_data_t             rdata_q;

    assign word_idx = i_bus.addr[wb_pkg::WB_ADDR_W-1:1];   // Byte to word.
    assign accept   = i_bus.cyc && i_bus.stb && !i_stall;

    always_ff @(posedge i_wb_clk or posedge i_wb_rst) begin
        if (i_wb_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            if (i_bus.we && (&i_bus.sel)) begin
                mem[word_idx] <= i_bus.data;
            end
            rdata_q <= mem[word_idx];                       // Old contents on a write.
        end
    end

    assign o_rsp = '{ack: ack_q, data: rdata_q};

    a_stb_in_cycle: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        i_bus.stb |-> i_bus.cyc);

endmodule

/* wb_ack_gather.sv */
module wb_ack_gather (
    input  logic               i_wb_clk,
    input  logic               i_wb_rst,
    input  logic               i_start,
    input  wb_pkg::wb_rsp_t    i_rsp,
    output logic               o_done,
    output cmd_pkg::cmd_data_t o_rd_data
);

    logic [cmd_pkg::BEAT_CNT_W-1:0] ack_cnt_q;
    logic                           last_ack;

    assign last_ack = i_rsp.ack &&
                      (ack_cnt_q == cmd_pkg::BEAT_CNT_W'(cmd_pkg::NUM_BEATS - 1));

    always_ff @(posedge i_wb_clk or posedge i_wb_rst) begin
        if (i_wb_rst) begin
            ack_cnt_q <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= last_ack;                             // One cycle after 4th ack.
            if (i_start) begin
                ack_cnt_q <= '0;
            end else if (i_rsp.ack) begin
                ack_cnt_q <= ack_cnt_q + 1'b1;
            end
        end
    end

    // Each beat enters at the top, so beat 0 ends up lowest.
    always_ff @(posedge i_wb_clk) begin
        if (i_rsp.ack) begin
            o_rd_data <= {i_rsp.data,
                          o_rd_data[cmd_pkg::CMD_DATA_W-1:wb_pkg::WB_DATA_W]};
        end
    end

    a_no_extra_ack: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        i_rsp.ack |-> (ack_cnt_q != cmd_pkg::BEAT_CNT_W'(cmd_pkg::NUM_BEATS)));

endmodule

/* wb_beat_issue.sv */
module wb_beat_issue (
    input  logic            i_wb_clk,
    input  logic            i_wb_rst,
    input  logic            i_start,
    input  cmd_pkg::plan_t  i_plan,
    input  logic            i_stall,
    input  logic            i_done,
    output wb_pkg::wb_req_t o_bus
);

    cmd_pkg::iss_state_t            state_q;
    logic                           cyc_q;
    logic [cmd_pkg::BEAT_CNT_W-1:0] beat_q;
    logic                           we_q;
    wb_pkg::wb_addr_t               addr_q;
    cmd_pkg::cmd_data_t             data_q;
    logic                           stb;
    logic                           accept;
    logic                           last_beat;

    assign stb       = (state_q == cmd_pkg::ISS_ISSUE);
    assign accept    = stb && !i_stall;
    assign last_beat = (beat_q == cmd_pkg::BEAT_CNT_W'(cmd_pkg::NUM_BEATS - 1));

    always_ff @(posedge i_wb_clk or posedge i_wb_rst) begin
        if (i_wb_rst) begin
            state_q <= cmd_pkg::ISS_IDLE;
            cyc_q   <= 1'b0;
            beat_q  <= '0;
        end else if (i_start) begin
            state_q <= cmd_pkg::ISS_ISSUE;
            cyc_q   <= 1'b1;
            beat_q  <= '0;
        end else begin
            if (accept) begin
                beat_q <= beat_q + 1'b1;
                if (last_beat) begin
                    state_q <= cmd_pkg::ISS_IDLE;           // Keep cyc until all acks.
                end
            end
            if (i_done) begin
                cyc_q <= 1'b0;
            end
        end
    end

    // Next beat's address and data move only on an accepted beat.
    always_ff @(posedge i_wb_clk) begin
        if (i_start) begin
            we_q   <= i_plan.we;
            addr_q <= i_plan.base;
            data_q <= i_plan.wdata;
        end else if (accept) begin
            addr_q <= addr_q + wb_pkg::wb_addr_t'(wb_pkg::WB_SEL_W);
            data_q <= {{wb_pkg::WB_DATA_W{1'b0}},
                       data_q[cmd_pkg::CMD_DATA_W-1:wb_pkg::WB_DATA_W]};
        end
    end

    always_comb begin
        o_bus.cyc  = cyc_q;
        o_bus.stb  = stb;
        o_bus.we   = we_q;
        o_bus.sel  = {wb_pkg::WB_SEL_W{stb}};
        o_bus.addr = addr_q;
        o_bus.data = data_q[wb_pkg::WB_DATA_W-1:0];       // Beat 0 is the low word.
    end

    a_stall_hold: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        (stb && i_stall) |=> (o_bus.stb && $stable(o_bus.addr) && $stable(o_bus.data)));

    a_start_idle_bus: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        i_start |-> !cyc_q);

endmodule

/* wb_cmd_decode.sv */
module wb_cmd_decode (
    input  logic               i_wb_clk,
    input  logic               i_wb_rst,
    input  logic               i_cmd_req,
    input  cmd_pkg::cmd_t      i_cmd,
    output logic               o_cmd_ack,
    output logic               o_cmd_err,
    output cmd_pkg::cmd_data_t o_rd_data,
    output logic               o_start,
    output cmd_pkg::plan_t     o_plan,
    input  logic               i_done,
    input  cmd_pkg::cmd_data_t i_gath_data
);

    cmd_pkg::hs_state_t state_q;
    logic               aligned;
    logic               accept;

    assign aligned   = (i_cmd.addr & wb_pkg::wb_addr_t'(cmd_pkg::CMD_BYTES - 1)) == '0;
    assign accept    = (state_q == cmd_pkg::HS_IDLE) && i_cmd_req;
    assign o_cmd_ack = (state_q == cmd_pkg::HS_ACK) || (state_q == cmd_pkg::HS_WAIT_LOW);

    always_ff @(posedge i_wb_clk or posedge i_wb_rst) begin
        if (i_wb_rst) begin
            state_q   <= cmd_pkg::HS_IDLE;
            o_start   <= 1'b0;
            o_cmd_err <= 1'b0;
        end else begin
            o_start <= 1'b0;
            case (state_q)
                cmd_pkg::HS_IDLE: begin
                    if (i_cmd_req) begin
                        o_cmd_err <= !aligned;
                        if (aligned) begin
                            o_start <= 1'b1;
                            state_q <= cmd_pkg::HS_RUN;
                        end else begin
                            state_q <= cmd_pkg::HS_ACK;     // Rejected without bus traffic.
                        end
                    end
                end
                cmd_pkg::HS_RUN: begin
                    if (i_done) begin
                        state_q <= cmd_pkg::HS_ACK;
                    end
                end
                cmd_pkg::HS_ACK: begin
                    if (!i_cmd_req) begin
                        state_q <= cmd_pkg::HS_WAIT_LOW;
                    end
                end
                default: begin
                    state_q <= cmd_pkg::HS_IDLE;            // Ack drops here.
                end
            endcase
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            o_plan <= '{we: i_cmd.we, base: i_cmd.addr, wdata: i_cmd.data};
            if (!aligned) begin
                o_rd_data <= '0;
            end
        end else if ((state_q == cmd_pkg::HS_RUN) && i_done) begin
            o_rd_data <= i_gath_data;
        end
    end

    a_start_from_idle: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_start |-> ($past(state_q) == cmd_pkg::HS_IDLE));

    a_ack_needs_req: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        $rose(o_cmd_ack) |-> $past(i_cmd_req));

endmodule

/* cmd_pkg.sv */
package cmd_pkg;

    localparam int CMD_DATA_W = 64;
    localparam int CMD_BYTES  = CMD_DATA_W / 8;      // Alignment of a command.
    localparam int NUM_BEATS  = CMD_DATA_W / wb_pkg::WB_DATA_W;
    localparam int BEAT_CNT_W = 3;

    typedef logic [CMD_DATA_W-1:0] cmd_data_t;

    typedef struct packed {
        logic             we;
        wb_pkg::wb_addr_t addr;
        cmd_data_t        data;
    } cmd_t;

    // Handed from decode to the issuer with the start strobe.
    typedef struct packed {
        logic             we;
        wb_pkg::wb_addr_t base;
        cmd_data_t        wdata;
    } plan_t;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_RUN,
        HS_ACK,
        HS_WAIT_LOW
    } hs_state_t;

    typedef enum logic {
        ISS_IDLE,
        ISS_ISSUE
    } iss_state_t;

endpackage

/* wb_pkg.sv */
package wb_pkg;

    localparam int WB_DATA_W    = 16;
    localparam int WB_ADDR_W    = 12;
    localparam int WB_SEL_W     = WB_DATA_W / 8;     // Bytes per beat.
    localparam int WB_MEM_DEPTH = 2 ** (WB_ADDR_W - 1);

    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;

    // Master to slave, one pipelined beat.
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_sel_t  sel;
        wb_addr_t addr;
        wb_data_t data;
    } wb_req_t;

    // Slave to master.
    typedef struct packed {
        logic     ack;
        wb_data_t data;
    } wb_rsp_t;

endpackage
